//--- all.f
+incdir+src
src/vid_pkg.sv
src/clk_pkg.sv
src/switch_conditioner.sv
src/mode_control.sv
src/video_timing.sv
src/video_top.sv
dv/tb_clk_gen.sv
dv/tb_video_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_video_top -f all.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0

//--- dv/tb_video_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "video_config.svh"

module tb_video_top;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DLY    = 2;
	localparam int SEL_HS       = 0;
	localparam int SEL_VS       = 1;
	localparam int SEL_DE       = 2;
	localparam int CHANGE_LIMIT = `DEBOUNCE_CYCLES + `GO_DELAY + 8; // Switch edge to go
	localparam int VGA_LINE     = `VGA_HPIXELS + `VGA_HFP + `VGA_HSW + `VGA_HBP;
	localparam int VGA_FRAME    = VGA_LINE * (`VGA_VLINES + `VGA_VFP + `VGA_VSW + `VGA_VBP);
	// SXGA has the longest line
	localparam int LINE_LIMIT   = 2 * (`SXGA_HPIXELS + `SXGA_HFP + `SXGA_HSW + `SXGA_HBP);
	localparam int WATCHDOG_CYCLES = 2 * VGA_FRAME + 16 * (CHANGE_LIMIT + 2 * LINE_LIMIT);

	logic               clk;
	logic               rst;
	logic [`SW_W-1:0]   sw;
	vid_pkg::mode_e     mode;
	clk_pkg::clk_prog_t clk_prog;
	logic               go;
	vid_pkg::sync_t     video;
	logic [31:0]        lfsr_state; // Random mode codes
	logic [`SW_W-1:0]   cur_code;   // Code the DUT should hold

	tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(8), .SKEW_NS(DRIVE_DLY)) u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	video_top u_dut (
		.clk50m_bufg (clk),
		.RSTBTN      (rst),
		.sw          (sw),
		.mode        (mode),
		.clk_prog    (clk_prog),
		.go          (go),
		.video       (video)
	);

	//////////////////////////////
	// Reporting and compares
	//////////////////////////////
	task automatic report_mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_timeout(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_prog(
		input clk_pkg::clk_prog_t got_prog,
		input clk_pkg::clk_prog_t exp_prog,
		input vid_pkg::mode_e     got_mode,
		input vid_pkg::mode_e     exp_mode
	);
		if (got_prog !== exp_prog || got_mode !== exp_mode)
			report_mismatch($sformatf("m=%0d d=%0d mode=%s, expected m=%0d d=%0d mode=%s",
				got_prog.m, got_prog.d, got_mode.name(), exp_prog.m, exp_prog.d,
				exp_mode.name()));
	endtask

	task automatic check_sync(input vid_pkg::sync_t got, input vid_pkg::sync_t exp,
		input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s hsync/vsync/de %b, expected %b", what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s %0d cycles, expected %0d", what, got, exp));
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	// Galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_code(output logic [`SW_W-1:0] code);
		for (int i = 0; i < `SW_W; i++) begin
			code[i]    = lfsr_state[0]; // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic drive_sw(input logic [`SW_W-1:0] code);
		@(posedge clk);
		#DRIVE_DLY sw = code;
	endtask

	// Mode table, unlisted codes give 720p
	task automatic expected_for(
		input  logic [`SW_W-1:0]   code,
		output vid_pkg::mode_e     exp_mode,
		output clk_pkg::clk_prog_t exp_prog,
		output int                 exp_line
	);
		case (code)
			4'b0000: begin
				exp_mode = vid_pkg::VGA;
				exp_prog = '{m: 8'(`VGA_M), d: 8'(`VGA_D)};
				exp_line = VGA_LINE;
			end
			4'b0001: begin
				exp_mode = vid_pkg::SVGA;
				exp_prog = '{m: 8'(`SVGA_M), d: 8'(`SVGA_D)};
				exp_line = `SVGA_HPIXELS + `SVGA_HFP + `SVGA_HSW + `SVGA_HBP;
			end
			4'b0011: begin
				exp_mode = vid_pkg::XGA;
				exp_prog = '{m: 8'(`XGA_M), d: 8'(`XGA_D)};
				exp_line = `XGA_HPIXELS + `XGA_HFP + `XGA_HSW + `XGA_HBP;
			end
			4'b1000: begin
				exp_mode = vid_pkg::SXGA;
				exp_prog = '{m: 8'(`SXGA_M), d: 8'(`SXGA_D)};
				exp_line = `SXGA_HPIXELS + `SXGA_HFP + `SXGA_HSW + `SXGA_HBP;
			end
			4'b1001: begin
				exp_mode = vid_pkg::CAMERA;
				exp_prog = '{m: 8'(`CAMERA_M), d: 8'(`CAMERA_D)};
				exp_line = `CAMERA_HPIXELS + `CAMERA_HFP + `CAMERA_HSW + `CAMERA_HBP;
			end
			default: begin
				exp_mode = vid_pkg::HDTV720P;
				exp_prog = '{m: 8'(`HDTV720P_M), d: 8'(`HDTV720P_D)};
				exp_line = `HDTV720P_HPIXELS + `HDTV720P_HFP + `HDTV720P_HSW + `HDTV720P_HBP;
			end
		endcase
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////
	task automatic wait_go(input int limit, input string what);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			n++;
			if (go)
				seen = 1'b1;
			else if (n >= limit)
				report_timeout($sformatf("No go pulse within %0d cycles %s", limit, what));
		end
	endtask

	task automatic expect_no_go(input int cycles, input string what);
		repeat (cycles) begin
			@(negedge clk);
			if (go)
				report_mismatch(what);
		end
	endtask

	function automatic logic sync_bit(input vid_pkg::sync_t v, input int which);
		case (which)
			SEL_HS:  return v.hsync;
			SEL_VS:  return v.vsync;
			default: return v.de;
		endcase
	endfunction

	// Width of the next run at lvl, and entry to entry period when full is set
	task automatic measure(input int which, input logic lvl, input logic full, input int limit,
		output int width, output int period);
		logic prev;
		logic cur;
		logic in_run;
		logic done;
		int   n;
		n    = 0;
		prev = sync_bit(video, which);
		@(negedge clk);
		cur = sync_bit(video, which);
		while (cur != lvl || prev == lvl) begin // Look for the entry
			prev = cur;
			@(negedge clk);
			cur = sync_bit(video, which);
			n++;
			if (n > limit)
				report_timeout($sformatf("Signal %0d never reached level %b", which, lvl));
		end
		width  = 1;
		period = 1;
		in_run = 1'b1;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk);
			cur = sync_bit(video, which);
			if (cur == lvl && !in_run) begin
				done = 1'b1; // Next entry
			end else if (cur == lvl) begin
				width++;
				period++;
			end else if (!full) begin
				done = 1'b1;
			end else begin
				in_run = 1'b0;
				period++;
			end
			if (period > limit)
				report_timeout($sformatf("Signal %0d stuck, no full period seen", which));
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic power_up_request;
		vid_pkg::mode_e     exp_mode;
		clk_pkg::clk_prog_t exp_prog;
		int                 line;
		repeat (3) @(negedge clk);
		check_sync(video, '0, "In reset"); // 720p idle levels
		if (go)
			report_mismatch("go high during reset");
		@(negedge rst);
		wait_go(`GO_DELAY + 2, "after reset release"); // Release lands mid-cycle
		expected_for(4'b0000, exp_mode, exp_prog, line);
		check_prog(clk_prog, exp_prog, mode, exp_mode);
		@(negedge clk);
		if (go)
			report_mismatch("go held longer than one cycle after reset");
	endtask

	task automatic vga_raster;
		int width;
		int period;
		check_sync(video, '{hsync: 1'b1, vsync: 1'b1, de: 1'b1}, "VGA live area"); // Sync idles high
		measure(SEL_HS, 1'b0, 1'b1, LINE_LIMIT, width, period);
		check_count(period, VGA_LINE, "VGA hsync period");
		check_count(width, `VGA_HSW, "VGA hsync width");
		measure(SEL_DE, 1'b1, 1'b0, LINE_LIMIT, width, period);
		check_count(width, `VGA_HPIXELS, "VGA de width");
		measure(SEL_VS, 1'b0, 1'b0, VGA_FRAME + VGA_LINE, width, period); // Up to one frame
		check_count(width, `VGA_VSW * VGA_LINE, "VGA vsync width");
	endtask

	task automatic svga_switch;
		vid_pkg::mode_e     exp_mode;
		clk_pkg::clk_prog_t exp_prog;
		int                 line;
		int                 width;
		int                 period;
		cur_code = 4'b0001;
		drive_sw(cur_code);
		wait_go(CHANGE_LIMIT, "after switch to SVGA");
		expected_for(cur_code, exp_mode, exp_prog, line);
		check_prog(clk_prog, exp_prog, mode, exp_mode);
		expect_no_go(CHANGE_LIMIT, "Second go pulse after SVGA switch");
		measure(SEL_HS, 1'b1, 1'b1, LINE_LIMIT, width, period); // Positive sync
		check_count(period, line, "SVGA hsync period");
		check_count(width, `SVGA_HSW, "SVGA hsync width");
	endtask

	task automatic debounce_reject;
		vid_pkg::mode_e     exp_mode;
		clk_pkg::clk_prog_t exp_prog;
		int                 line;
		drive_sw(4'b1000);
		repeat (`DEBOUNCE_CYCLES / 2 - 1) @(posedge clk);
		drive_sw(cur_code); // Glitch ends well short of the debounce
		expect_no_go(CHANGE_LIMIT, "go pulse after a short glitch");
		expected_for(cur_code, exp_mode, exp_prog, line);
		check_prog(clk_prog, exp_prog, mode, exp_mode);
	endtask

	task automatic random_modes;
		logic [`SW_W-1:0]   code;
		vid_pkg::mode_e     exp_mode;
		clk_pkg::clk_prog_t exp_prog;
		int                 line;
		int                 width;
		int                 period;
		for (int i = 0; i < 6; i++) begin
			draw_code(code);
			while (code == cur_code)
				draw_code(code); // Same code makes no request
			cur_code = code;
			drive_sw(code);
			wait_go(CHANGE_LIMIT, $sformatf("for code %b", code));
			expected_for(code, exp_mode, exp_prog, line);
			check_prog(clk_prog, exp_prog, mode, exp_mode);
			measure(SEL_HS, 1'b1, 1'b1, LINE_LIMIT, width, period); // Either polarity
			check_count(period, line, $sformatf("hsync period for code %b", code));
		end
	endtask

	initial begin
		sw         = '0; // VGA through reset
		lfsr_state = 32'h6dc9668b;
		cur_code   = '0;
		power_up_request();
		vga_raster();
		svga_switch();
		debounce_reject();
		random_modes();
		$display("No errors");
		$finish;
	end

	// Bounded by two VGA frames plus the mode changes
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before tests finished");
		$display("Errors found");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 8,
	parameter int SKEW_NS    = 2 // Input skew after the rising edge
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1; // Held from time zero
		repeat (RST_CYCLES) @(posedge clk);
		#SKEW_NS rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- src/video_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "video_config.svh"

module video_top (
	input  wire                clk50m_bufg,
	input  wire                RSTBTN,
	input  wire  [`SW_W-1:0]   sw,       // Mode switches
	output vid_pkg::mode_e     mode,
	output clk_pkg::clk_prog_t clk_prog, // Pixel clock M/D
	output logic               go,       // Synthesizer program strobe
	output vid_pkg::sync_t     video
);

	logic [`SW_W-1:0] sw_stable;
	logic             sw_change;
	vid_pkg::timing_t timing;
	logic             restart;

	switch_conditioner u_switch (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.sw_stable   (sw_stable),
		.sw_change   (sw_change)
	);

	mode_control u_mode (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw_stable   (sw_stable),
		.sw_change   (sw_change),
		.mode        (mode),
		.timing      (timing),
		.restart     (restart),
		.clk_prog    (clk_prog),
		.go          (go)
	);

	video_timing u_timing (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.timing      (timing),
		.restart     (restart),
		.video       (video)
	);

endmodule

`default_nettype wire

//--- src/video_timing.sv
`default_nettype none
`timescale 1ns/10ps

module video_timing (
	input  wire              clk50m_bufg,
	input  wire              RSTBTN,
	input  vid_pkg::timing_t timing,  // Held by mode control
	input  wire              restart, // Start a new frame
	output vid_pkg::sync_t   video
);

	vid_pkg::count_t hcount; // Pixel within line
	vid_pkg::count_t vcount; // Line within frame
	logic            h_end;
	logic            hs_raw; // Sync before polarity
	logic            vs_raw;
	logic            active; // Inside the live window
	vid_pkg::sync_t  stage1;

	//////////////////////////////
	// Raster counters
	//////////////////////////////
	assign h_end = (hcount >= timing.heblnk); // Also catches a shorter new table

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_end) begin
			hcount <= '0;
			if (vcount >= timing.veblnk)
				vcount <= '0; // Frame wrap
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	//////////////////////////////
	// Blanking and sync decode
	//////////////////////////////
	assign active = (hcount <= timing.hsblnk) && (vcount <= timing.vsblnk);
	assign hs_raw = (hcount > timing.hssync) && (hcount <= timing.hesync);
	assign vs_raw = (vcount > timing.vssync) && (vcount <= timing.vesync);

	// Two stages, polarity applied in the first
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			stage1 <= '0; // Inactive for 720p positive sync
			video  <= '0;
		end else begin
			stage1.hsync <= hs_raw ^ timing.neg_sync;
			stage1.vsync <= vs_raw ^ timing.neg_sync;
			stage1.de    <= active;
			video        <= stage1;
		end
	end

	// Live pixels and sync pulse never overlap at the pins
	a_de_outside_sync: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		video.de |-> !$past(hs_raw, 2));

endmodule

`default_nettype wire

//--- src/mode_control.sv
`default_nettype none
`timescale 1ns/10ps

`include "video_config.svh"

module mode_control (
	input  wire               clk50m_bufg,
	input  wire               RSTBTN,
	input  wire  [`SW_W-1:0]  sw_stable,
	input  wire               sw_change,
	output vid_pkg::mode_e    mode,
	output vid_pkg::timing_t  timing,   // Table for the raster counters
	output logic              restart,  // Counters back to zero
	output clk_pkg::clk_prog_t clk_prog, // Held M/D for the synthesizer
	output logic              go        // Program request, one cycle
);

	vid_pkg::mode_e        new_mode;
	logic [`GO_DELAY-1:0]  go_sr; // Delay line for the request

	// Unlisted codes map to 720p
	function automatic vid_pkg::mode_e decode_mode(input logic [`SW_W-1:0] code);
		case (code)
			vid_pkg::VGA, vid_pkg::SVGA, vid_pkg::XGA, vid_pkg::SXGA, vid_pkg::CAMERA:
				return vid_pkg::mode_e'(code);
			default:
				return vid_pkg::HDTV720P;
		endcase
	endfunction

	// Running sums of region lengths, minus one for zero-based counters
	function automatic vid_pkg::timing_t build_timing(
		input int   hpix,
		input int   hfp,
		input int   hsw,
		input int   hbp,
		input int   vlin,
		input int   vfp,
		input int   vsw,
		input int   vbp,
		input logic neg
	);
		vid_pkg::timing_t t;
		t.hsblnk   = vid_pkg::count_t'(hpix - 1);
		t.hssync   = vid_pkg::count_t'(hpix - 1 + hfp);
		t.hesync   = vid_pkg::count_t'(hpix - 1 + hfp + hsw);
		t.heblnk   = vid_pkg::count_t'(hpix - 1 + hfp + hsw + hbp); // Line wraps here
		t.vsblnk   = vid_pkg::count_t'(vlin - 1);
		t.vssync   = vid_pkg::count_t'(vlin - 1 + vfp);
		t.vesync   = vid_pkg::count_t'(vlin - 1 + vfp + vsw);
		t.veblnk   = vid_pkg::count_t'(vlin - 1 + vfp + vsw + vbp);
		t.neg_sync = neg;
		return t;
	endfunction

	function automatic vid_pkg::timing_t mode_timing(input vid_pkg::mode_e m);
		case (m)
			vid_pkg::VGA: return build_timing(`VGA_HPIXELS, `VGA_HFP, `VGA_HSW, `VGA_HBP,
				`VGA_VLINES, `VGA_VFP, `VGA_VSW, `VGA_VBP, 1'b1); // Negative sync
			vid_pkg::SVGA: return build_timing(`SVGA_HPIXELS, `SVGA_HFP, `SVGA_HSW, `SVGA_HBP,
				`SVGA_VLINES, `SVGA_VFP, `SVGA_VSW, `SVGA_VBP, 1'b0);
			vid_pkg::XGA: return build_timing(`XGA_HPIXELS, `XGA_HFP, `XGA_HSW, `XGA_HBP,
				`XGA_VLINES, `XGA_VFP, `XGA_VSW, `XGA_VBP, 1'b1); // Negative sync
			vid_pkg::SXGA: return build_timing(`SXGA_HPIXELS, `SXGA_HFP, `SXGA_HSW, `SXGA_HBP,
				`SXGA_VLINES, `SXGA_VFP, `SXGA_VSW, `SXGA_VBP, 1'b0);
			vid_pkg::CAMERA: return build_timing(`CAMERA_HPIXELS, `CAMERA_HFP, `CAMERA_HSW,
				`CAMERA_HBP, `CAMERA_VLINES, `CAMERA_VFP, `CAMERA_VSW, `CAMERA_VBP, 1'b0);
			default: return build_timing(`HDTV720P_HPIXELS, `HDTV720P_HFP, `HDTV720P_HSW,
				`HDTV720P_HBP, `HDTV720P_VLINES, `HDTV720P_VFP, `HDTV720P_VSW,
				`HDTV720P_VBP, 1'b0);
		endcase
	endfunction

	function automatic clk_pkg::clk_prog_t build_prog(input int m, input int d);
		clk_pkg::clk_prog_t p;
		p.m = clk_pkg::prog_val_t'(m);
		p.d = clk_pkg::prog_val_t'(d);
		return p;
	endfunction

	function automatic clk_pkg::clk_prog_t mode_prog(input vid_pkg::mode_e m);
		case (m)
			vid_pkg::VGA:    return build_prog(`VGA_M, `VGA_D);
			vid_pkg::SVGA:   return build_prog(`SVGA_M, `SVGA_D);
			vid_pkg::XGA:    return build_prog(`XGA_M, `XGA_D);
			vid_pkg::SXGA:   return build_prog(`SXGA_M, `SXGA_D);
			vid_pkg::CAMERA: return build_prog(`CAMERA_M, `CAMERA_D);
			default:         return build_prog(`HDTV720P_M, `HDTV720P_D);
		endcase
	endfunction

	assign new_mode = decode_mode(sw_stable);
	assign go       = go_sr[`GO_DELAY-1]; // Oldest stage

	//////////////////////////////
	// Mode latch and go delay
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			mode     <= vid_pkg::HDTV720P; // 720p until the first request lands
			timing   <= mode_timing(vid_pkg::HDTV720P);
			clk_prog <= mode_prog(vid_pkg::HDTV720P);
			restart  <= 1'b0;
			go_sr    <= '0;
		end else begin
			restart <= sw_change; // Same cycle as the table update
			go_sr   <= {go_sr[`GO_DELAY-2:0], sw_change};
			if (sw_change) begin
				mode     <= new_mode;
				timing   <= mode_timing(new_mode);
				clk_prog <= mode_prog(new_mode);
			end
		end
	end

	// Synthesizer takes exactly one request per change
	a_go_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		go |=> !go);

endmodule

`default_nettype wire

//--- src/switch_conditioner.sv
`default_nettype none
`timescale 1ns/10ps

`include "video_config.svh"

module switch_conditioner (
	input  wire              clk50m_bufg,
	input  wire              RSTBTN,
	input  wire  [`SW_W-1:0] sw,        // Raw switches, asynchronous
	output logic [`SW_W-1:0] sw_stable, // Last accepted code
	output logic             sw_change  // One cycle per accepted code
);

	localparam int DB_W = $clog2(`DEBOUNCE_CYCLES);

	logic [`SW_W-1:0] sw_meta;   // First sync stage
	logic [`SW_W-1:0] sw_sync;   // Second sync stage
	logic [`SW_W-1:0] sw_last;   // Previous synchronized value
	logic [DB_W-1:0]  db_cnt;    // Cycles the candidate has held
	logic             init_pend; // Power-up request still owed
	logic             cand_ok;

	//////////////////////////////
	// Synchronizer
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
		sw_last <= sw_sync;
	end

	// New value, unchanged since last cycle
	assign cand_ok = (sw_sync == sw_last) && (sw_sync != sw_stable);

	//////////////////////////////
	// Debounce and accept
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_stable <= sw_sync; // Start from the switches as held in reset
			db_cnt    <= '0;
			init_pend <= 1'b1;
			sw_change <= 1'b0;
		end else if (init_pend) begin
			sw_stable <= sw_sync; // First request after reset
			db_cnt    <= '0;
			init_pend <= 1'b0;
			sw_change <= 1'b1;
		end else if (!cand_ok) begin
			db_cnt    <= '0; // Bounce or no change, start over
			sw_change <= 1'b0;
		end else if (db_cnt == DB_W'(`DEBOUNCE_CYCLES - 1)) begin
			sw_stable <= sw_sync;
			db_cnt    <= '0;
			sw_change <= 1'b1;
		end else begin
			db_cnt    <= db_cnt + 1'b1;
			sw_change <= 1'b0;
		end
	end

	// Mode control relies on isolated change pulses
	a_change_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		sw_change |=> !sw_change);

endmodule

`default_nettype wire

//--- src/clk_pkg.sv
`default_nettype none

package clk_pkg;

	// One synthesizer field, stored as value minus one
	typedef logic [7:0] prog_val_t;

	// Programming word for the pixel clock synthesizer
	typedef struct packed {
		prog_val_t m; // Multiplier
		prog_val_t d; // Divider
	} clk_prog_t;

endpackage

`default_nettype wire

//--- src/vid_pkg.sv
`default_nettype none

`include "video_config.svh"

package vid_pkg;

	// Switch codes, anything unlisted falls back to 720p
	typedef enum logic [`SW_W-1:0] {
		VGA      = 4'b0000,
		SVGA     = 4'b0001,
		XGA      = 4'b0011,
		HDTV720P = 4'b0010,
		SXGA     = 4'b1000,
		CAMERA   = 4'b1001
	} mode_e;

	typedef logic [`VID_CNT_W-1:0] count_t; // Pixel or line count

	// End-of-region counts, each is the last count inside its region
	typedef struct packed {
		count_t hsblnk; // Last live pixel
		count_t hssync; // Last front porch pixel
		count_t hesync; // Last sync pixel
		count_t heblnk; // Last pixel of the line
		count_t vsblnk; // Last live line
		count_t vssync;
		count_t vesync;
		count_t veblnk; // Last line of the frame
		logic   neg_sync; // Sync active low
	} timing_t;

	// Raster outputs
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} sync_t;

endpackage

`default_nettype wire

//--- src/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

//////////////////////////////
// Widths and delays
//////////////////////////////
`define VID_CNT_W        11 // Raster counter bits
`define SW_W             4  // Mode switch bits
`define DEBOUNCE_CYCLES  64 // Stable cycles before a switch value is taken
`define GO_DELAY         16 // Accepted change to synthesizer go

//////////////////////////////
// Raster per mode
//////////////////////////////
// 640x480@60, 25 MHz
`define VGA_HPIXELS      640
`define VGA_HFP          16
`define VGA_HSW          96
`define VGA_HBP          48
`define VGA_VLINES       480
`define VGA_VFP          11
`define VGA_VSW          2
`define VGA_VBP          31

// 800x600@60, 40 MHz
`define SVGA_HPIXELS     800
`define SVGA_HFP         40
`define SVGA_HSW         128
`define SVGA_HBP         88
`define SVGA_VLINES      600
`define SVGA_VFP         1
`define SVGA_VSW         4
`define SVGA_VBP         23

// 1024x768@60, 65 MHz
`define XGA_HPIXELS      1024
`define XGA_HFP          24
`define XGA_HSW          136
`define XGA_HBP          160
`define XGA_VLINES       768
`define XGA_VFP          3
`define XGA_VSW          6
`define XGA_VBP          29

`define HDTV720P_HPIXELS 1280 // 1280x720@60, 74.25 MHz
`define HDTV720P_HFP     110
`define HDTV720P_HSW     40
`define HDTV720P_HBP     220
`define HDTV720P_VLINES  720
`define HDTV720P_VFP     5
`define HDTV720P_VSW     5
`define HDTV720P_VBP     20

`define SXGA_HPIXELS     1280 // 1280x1024@60, 108 MHz
`define SXGA_HFP         48
`define SXGA_HSW         112
`define SXGA_HBP         248
`define SXGA_VLINES      1024
`define SXGA_VFP         1
`define SXGA_VSW         3
`define SXGA_VBP         38

`define CAMERA_HPIXELS   1280 // Camera variant of 720p
`define CAMERA_HFP       110
`define CAMERA_HSW       39
`define CAMERA_HBP       220
`define CAMERA_VLINES    720
`define CAMERA_VFP       4
`define CAMERA_VSW       4
`define CAMERA_VBP       22

//////////////////////////////
// Synthesizer M/D, minus one
//////////////////////////////
`define VGA_M            1
`define VGA_D            3
`define SVGA_M           3
`define SVGA_D           4
`define XGA_M            12
`define XGA_D            9
`define SXGA_M           53
`define SXGA_D           24
`define CAMERA_M         134
`define CAMERA_D         90
`define HDTV720P_M       247 // Also the fallback for unlisted codes
`define HDTV720P_D       166

`endif
